// File: design/ac_defines.svh
// Accumulator unit widths and counts

`ifndef AC_DEFINES_SVH
`define AC_DEFINES_SVH

// machine word
`define AC_WORD_WIDTH 12

// step counter, wide enough for a shift of 24
`define AC_COUNT_WIDTH 5

// one iteration per multiplier bit
`define AC_MUL_STEPS 12

// shift counts at or above this saturate in one step
`define AC_SHIFT_LIMIT 24

`endif

// File: design/ac_pkg.sv
// Accumulator unit types

`default_nettype none

`include "ac_defines.svh"

package ac_pkg;

    // one machine word, msb is the sign
    typedef logic [`AC_WORD_WIDTH-1:0] word_t;

    // shift count or step count
    typedef logic [`AC_COUNT_WIDTH-1:0] count_t;

    // instruction classes seen by the datapath
    typedef enum logic [3:0]
    {
        OP_NONE,   // anything not handled here
        OP_AND,    // 0xxx
        OP_TAD,    // 1xxx
        OP_DCA,    // 3xxx
        OP_GROUP1, // operate group 1
        OP_GROUP3, // mq micro-ops
        OP_MUL,    // 7405
        OP_SHL,    // 7413
        OP_LSR,    // 7417
        OP_ASR     // 7415
    } op_class_t;

endpackage

`default_nettype wire

// File: design/instr_decode.sv
// Instruction class decoder

`default_nettype none

module instr_decode
(
    input wire ac_pkg::word_t instruction,
    output ac_pkg::op_class_t op_class,
    output ac_pkg::word_t micro_bits
);

    // major opcode field
    localparam logic [2:0] OPC_AND = 3'o0;
    localparam logic [2:0] OPC_TAD = 3'o1;
    localparam logic [2:0] OPC_DCA = 3'o3;
    localparam logic [2:0] OPC_OPR = 3'o7;

    // extended arithmetic codes, matched exactly
    localparam ac_pkg::word_t INSTR_MUL = 12'o7405;
    localparam ac_pkg::word_t INSTR_SHL = 12'o7413;
    localparam ac_pkg::word_t INSTR_ASR = 12'o7415;
    localparam ac_pkg::word_t INSTR_LSR = 12'o7417;

    logic [2:0] opcode;
    logic group_bit; // 0400
    logic low_bit; // 0001, marks group 3

    assign opcode = instruction[11:9];
    assign group_bit = instruction[8];
    assign low_bit = instruction[0];

    // opcode field stripped, micro-op bits left in place
    assign micro_bits = {3'b000, instruction[8:0]};

    always_comb
    begin
        op_class = ac_pkg::OP_NONE;
        case (opcode)
            OPC_AND: op_class = ac_pkg::OP_AND;
            OPC_TAD: op_class = ac_pkg::OP_TAD;
            OPC_DCA: op_class = ac_pkg::OP_DCA;
            OPC_OPR:
            begin
                if (!group_bit)
                begin
                    op_class = ac_pkg::OP_GROUP1;
                end
                else if (low_bit)
                begin
                    case (instruction)
                        INSTR_MUL: op_class = ac_pkg::OP_MUL;
                        INSTR_SHL: op_class = ac_pkg::OP_SHL;
                        INSTR_ASR: op_class = ac_pkg::OP_ASR;
                        INSTR_LSR: op_class = ac_pkg::OP_LSR;
                        default: op_class = ac_pkg::OP_GROUP3; // mq micro-ops
                    endcase
                end
                else
                begin
                    op_class = ac_pkg::OP_NONE; // group 2, not handled here
                end
            end
            default: op_class = ac_pkg::OP_NONE; // jumps, isz, iot
        endcase
    end

endmodule

`default_nettype wire

// File: design/operate_unit.sv
// Single-cycle result logic

`default_nettype none

`include "ac_defines.svh"

module operate_unit
(
    input wire ac_pkg::op_class_t op_class,
    input wire ac_pkg::word_t micro_bits,
    input wire ac_pkg::word_t ac,
    input wire ac_pkg::word_t mq,
    input wire ac_pkg::word_t operand,
    input wire link,
    output ac_pkg::word_t next_ac,
    output ac_pkg::word_t next_mq,
    output logic next_link
);

    localparam int W = `AC_WORD_WIDTH;
    localparam int H = W / 2; // byte swap half

    logic [W:0] g1_lac; // link in the top bit
    logic [W:0] tad_sum;
    ac_pkg::word_t g3_base;
    ac_pkg::word_t g3_ac;
    ac_pkg::word_t g3_mq;

    // group 1, micro-ops in their fixed order
    always_comb
    begin
        g1_lac = {link, ac};
        if (micro_bits[7]) g1_lac[W-1:0] = '0; // cla
        if (micro_bits[6]) g1_lac[W] = 1'b0; // cll
        if (micro_bits[5]) g1_lac[W-1:0] = ~g1_lac[W-1:0]; // cma
        if (micro_bits[4]) g1_lac[W] = ~g1_lac[W]; // cml
        if (micro_bits[0]) g1_lac = g1_lac + 1'b1; // iac, carry flips link
        case (micro_bits[3:1])
            3'b001: g1_lac = {g1_lac[W], g1_lac[H-1:0], g1_lac[W-1:H]}; // bsw
            3'b010: g1_lac = {g1_lac[W-1:0], g1_lac[W]}; // ral
            3'b011: g1_lac = {g1_lac[W-2:0], g1_lac[W:W-1]}; // rtl
            3'b100: g1_lac = {g1_lac[0], g1_lac[W:1]}; // rar
            3'b101: g1_lac = {g1_lac[1:0], g1_lac[W:2]}; // rtr
            default: ; // no rotate
        endcase
    end

    // group 3, cla first then mqa/mql
    always_comb
    begin
        g3_base = micro_bits[7] ? '0 : ac;
        case ({micro_bits[6], micro_bits[4]})
            2'b01:
            begin
                g3_ac = '0; // mql
                g3_mq = g3_base;
            end
            2'b10:
            begin
                g3_ac = g3_base | mq; // mqa
                g3_mq = mq;
            end
            2'b11:
            begin
                g3_ac = mq; // swp
                g3_mq = g3_base;
            end
            default:
            begin
                g3_ac = g3_base;
                g3_mq = mq;
            end
        endcase
    end

    assign tad_sum = {link, ac} + {1'b0, operand}; // carry flips link

    always_comb
    begin
        next_ac = ac;
        next_mq = mq;
        next_link = link;
        case (op_class)
            ac_pkg::OP_AND: next_ac = ac & operand;
            ac_pkg::OP_TAD: {next_link, next_ac} = tad_sum;
            ac_pkg::OP_DCA: next_ac = '0; // store done elsewhere, ac cleared
            ac_pkg::OP_GROUP1: {next_link, next_ac} = g1_lac;
            ac_pkg::OP_GROUP3:
            begin
                next_ac = g3_ac;
                next_mq = g3_mq;
            end
            default: ; // eae classes and no-ops hold
        endcase
    end

endmodule

`default_nettype wire

// File: design/eae_unit.sv
// Iterative multiply and shift engine

`default_nettype none

`include "ac_defines.svh"

module eae_unit
(
    input wire clk,
    input wire reset,
    input wire eae_start,
    input wire ac_pkg::op_class_t op_class,
    input wire ac_pkg::word_t ac,
    input wire ac_pkg::word_t mq,
    input wire ac_pkg::word_t operand,
    input wire link,
    output ac_pkg::word_t eae_ac,
    output ac_pkg::word_t eae_mq,
    output logic eae_link,
    output logic eae_done
);

    localparam int W = `AC_WORD_WIDTH;

    ac_pkg::op_class_t op_q; // class latched at load
    ac_pkg::word_t md_q; // multiplicand
    ac_pkg::word_t w_ac;
    ac_pkg::word_t w_mq;
    logic w_link;
    ac_pkg::count_t count; // steps left
    logic running;

    ac_pkg::count_t shift_n;
    ac_pkg::count_t load_count;
    logic saturate;
    logic sign;
    logic [W:0] mul_sum;

    assign shift_n = operand[`AC_COUNT_WIDTH-1:0];
    assign saturate = shift_n >= ac_pkg::count_t'(`AC_SHIFT_LIMIT);
    assign sign = ac[W-1];
    assign mul_sum = {1'b0, w_ac} + {1'b0, md_q};

    // a saturated load needs one step, shifting it again changes nothing
    always_comb
    begin
        if (op_class == ac_pkg::OP_MUL)
            load_count = ac_pkg::count_t'(`AC_MUL_STEPS);
        else if (saturate)
            load_count = ac_pkg::count_t'(1);
        else
            load_count = shift_n + ac_pkg::count_t'(1); // n+1 places
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            running <= 1'b0;
            count <= '0;
            eae_done <= 1'b0;
        end
        else
        begin
            eae_done <= 1'b0;
            if (eae_start)
            begin
                running <= 1'b1;
                count <= load_count;
            end
            else if (running)
            begin
                count <= count - ac_pkg::count_t'(1);
                if (count == ac_pkg::count_t'(1))
                begin
                    running <= 1'b0; // last step
                    eae_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (eae_start)
        begin
            op_q <= op_class;
            md_q <= operand;
            case (op_class)
                ac_pkg::OP_MUL: {w_link, w_ac, w_mq} <= {1'b0, ac, mq};
                ac_pkg::OP_SHL: {w_link, w_ac, w_mq} <= saturate ? '0 : {link, ac, mq};
                ac_pkg::OP_LSR: {w_link, w_ac, w_mq} <= saturate ? '0 : {1'b0, ac, mq};
                ac_pkg::OP_ASR:
                begin
                    w_link <= sign; // link takes the sign
                    w_ac <= saturate ? {W{sign}} : ac;
                    w_mq <= saturate ? {W{sign}} : mq;
                end
                default: {w_link, w_ac, w_mq} <= {link, ac, mq};
            endcase
        end
        else if (running)
        begin
            case (op_q)
                ac_pkg::OP_MUL:
                begin
                    if (w_mq[0])
                        {w_ac, w_mq} <= {mul_sum, w_mq[W-1:1]}; // add then shift
                    else
                        {w_ac, w_mq} <= {1'b0, w_ac, w_mq[W-1:1]};
                end
                ac_pkg::OP_SHL: {w_link, w_ac, w_mq} <= {w_ac, w_mq, 1'b0};
                ac_pkg::OP_LSR,
                ac_pkg::OP_ASR: {w_ac, w_mq} <= {w_link, w_ac, w_mq[W-1:1]}; // link is fill
                default: ;
            endcase
        end
    end

    assign eae_ac = w_ac;
    assign eae_mq = w_mq;
    assign eae_link = w_link;

endmodule

`default_nettype wire

// File: design/ac_control.sv
// Register and sequence control

`default_nettype none

module ac_control
(
    input wire clk,
    input wire reset,
    input wire start,
    input wire ac_pkg::op_class_t op_class,
    input wire ac_pkg::word_t next_ac,
    input wire ac_pkg::word_t next_mq,
    input wire ac_pkg::word_t eae_ac,
    input wire ac_pkg::word_t eae_mq,
    input wire next_link,
    input wire eae_link,
    input wire eae_done,
    output ac_pkg::word_t ac,
    output ac_pkg::word_t mq,
    output logic link,
    output logic busy,
    output logic done,
    output logic eae_start
);

    typedef enum logic {ST_IDLE, ST_ITER} state_t;

    state_t state;
    logic is_eae; // needs the iterative engine

    assign is_eae = (op_class == ac_pkg::OP_MUL) ||
                    (op_class == ac_pkg::OP_SHL) ||
                    (op_class == ac_pkg::OP_LSR) ||
                    (op_class == ac_pkg::OP_ASR);

    assign busy = (state == ST_ITER);
    assign eae_start = start && (state == ST_IDLE) && is_eae; // engine loads this edge

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            ac <= '0;
            mq <= '0;
            link <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (start && is_eae)
                    begin
                        state <= ST_ITER; // busy from next cycle
                    end
                    else if (start)
                    begin
                        ac <= next_ac; // single-cycle commit
                        mq <= next_mq;
                        link <= next_link;
                        done <= 1'b1;
                    end
                end
                ST_ITER:
                begin
                    if (eae_done) // start ignored in here
                    begin
                        ac <= eae_ac;
                        mq <= eae_mq;
                        link <= eae_link;
                        done <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/ac_top.sv
// Accumulator unit top level

`default_nettype none

module ac_top
(
    input wire clk,
    input wire reset,
    input wire start,
    input wire ac_pkg::word_t instruction,
    input wire ac_pkg::word_t operand, // memory data, shift count in low bits
    output wire ac_pkg::word_t ac,
    output wire ac_pkg::word_t mq,
    output wire link,
    output wire busy,
    output wire done
);

    wire ac_pkg::op_class_t op_class;
    wire ac_pkg::word_t micro_bits;
    wire ac_pkg::word_t next_ac;
    wire ac_pkg::word_t next_mq;
    wire next_link;
    wire ac_pkg::word_t eae_ac;
    wire ac_pkg::word_t eae_mq;
    wire eae_link;
    wire eae_done;
    wire eae_start;

    instr_decode u_decode
    (
        .instruction (instruction),
        .op_class    (op_class),
        .micro_bits  (micro_bits)
    );

    operate_unit u_operate
    (
        .op_class   (op_class),
        .micro_bits (micro_bits),
        .ac         (ac),
        .mq         (mq),
        .operand    (operand),
        .link       (link),
        .next_ac    (next_ac),
        .next_mq    (next_mq),
        .next_link  (next_link)
    );

    eae_unit u_eae
    (
        .clk       (clk),
        .reset     (reset),
        .eae_start (eae_start),
        .op_class  (op_class),
        .ac        (ac),
        .mq        (mq),
        .operand   (operand),
        .link      (link),
        .eae_ac    (eae_ac),
        .eae_mq    (eae_mq),
        .eae_link  (eae_link),
        .eae_done  (eae_done)
    );

    ac_control u_control
    (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .op_class  (op_class),
        .next_ac   (next_ac),
        .next_mq   (next_mq),
        .eae_ac    (eae_ac),
        .eae_mq    (eae_mq),
        .next_link (next_link),
        .eae_link  (eae_link),
        .eae_done  (eae_done),
        .ac        (ac),
        .mq        (mq),
        .link      (link),
        .busy      (busy),
        .done      (done),
        .eae_start (eae_start)
    );

endmodule

`default_nettype wire

// File: testbench/ac_model.svh
// Accumulator unit reference model

`ifndef AC_MODEL_SVH
`define AC_MODEL_SVH

`include "ac_defines.svh"

ac_pkg::word_t exp_ac; // model copies of the registers
ac_pkg::word_t exp_mq;
logic exp_link;

function automatic void operate_group1(input ac_pkg::word_t instr);
    logic [12:0] lac;
    int places;
    lac = {exp_link, exp_ac};
    if (instr[7]) lac[11:0] = '0; // cla
    if (instr[6]) lac[12] = 1'b0; // cll
    if (instr[5]) lac[11:0] = ~lac[11:0]; // cma
    if (instr[4]) lac[12] = ~lac[12]; // cml
    if (instr[0]) lac = lac + 13'd1; // iac with the carry into link
    places = instr[1] ? 2 : 1; // rtr and rtl go two places
    if (instr[3:1] == 3'b001)
        lac = {lac[12], lac[5:0], lac[11:6]}; // bsw leaves link alone
    else if (instr[3:1] == 3'b100 || instr[3:1] == 3'b101)
        for (int i = 0; i < places; i++)
            lac = {lac[0], lac[12:1]}; // right through link
    else if (instr[3:1] == 3'b010 || instr[3:1] == 3'b011)
        for (int i = 0; i < places; i++)
            lac = {lac[11:0], lac[12]}; // left through link
    {exp_link, exp_ac} = lac;
endfunction

function automatic void mq_micro_ops(input ac_pkg::word_t instr);
    ac_pkg::word_t base;
    base = instr[7] ? '0 : exp_ac; // cla comes first
    if (instr[6] && instr[4])
    begin
        exp_ac = exp_mq; // swp
        exp_mq = base;
    end
    else if (instr[6])
        exp_ac = base | exp_mq; // mqa
    else if (instr[4])
    begin
        exp_mq = base; // mql
        exp_ac = '0;
    end
    else
        exp_ac = base;
endfunction

function automatic int multiply(input ac_pkg::word_t opnd);
    logic [23:0] product;
    product = 24'(exp_mq) * 24'(opnd) + 24'(exp_ac);
    {exp_ac, exp_mq} = product;
    exp_link = 1'b0;
    return `AC_MUL_STEPS;
endfunction

function automatic int eae_shift(input ac_pkg::word_t instr, input logic [4:0] n);
    logic [24:0] wide;
    logic signed [23:0] pair;
    logic sat;
    sat = n >= `AC_SHIFT_LIMIT;
    wide = {exp_link, exp_ac, exp_mq};
    pair = {exp_ac, exp_mq};
    if (instr == 12'o7413)
        {exp_link, exp_ac, exp_mq} = sat ? 25'd0 : wide << (n + 1); // shl
    else if (instr == 12'o7417)
        {exp_link, exp_ac, exp_mq} = sat ? 25'd0 : {1'b0, wide[23:0] >> (n + 1)}; // lsr
    else
    begin
        if (sat)
            pair = {24{exp_ac[11]}}; // asr saturates to the sign
        else
            pair = pair >>> (n + 1);
        {exp_link, exp_ac, exp_mq} = {exp_ac[11], pair};
    end
    return sat ? 1 : int'(n) + 1;
endfunction

// updates the model and returns the cycle in which done should be seen
function automatic int predict(input ac_pkg::word_t instr, input ac_pkg::word_t opnd);
    int steps;
    logic [12:0] sum;
    steps = 0;
    case (instr[11:9])
        3'o0: exp_ac = exp_ac & opnd; // and
        3'o1:
        begin
            sum = {1'b0, exp_ac} + {1'b0, opnd}; // tad
            exp_ac = sum[11:0];
            exp_link = exp_link ^ sum[12]; // carry toggles link
        end
        3'o3: exp_ac = '0; // dca
        3'o7:
        begin
            if (!instr[8])
                operate_group1(instr);
            else if (instr == 12'o7405)
                steps = multiply(opnd);
            else if (instr == 12'o7413 || instr == 12'o7415 || instr == 12'o7417)
                steps = eae_shift(instr, opnd[4:0]);
            else if (instr[0])
                mq_micro_ops(instr);
        end
        default: ; // no-op
    endcase
    // engine steps plus the load and commit edges
    return (steps == 0) ? 1 : steps + 2;
endfunction

`endif

// File: testbench/ac_tb.sv
// Accumulator unit testbench

`default_nettype none

`include "ac_defines.svh"

module ac_tb;

    localparam int CLK_PERIOD = 8;
    localparam int GROUP1_TESTS = 40;
    localparam int MEMREF_TESTS = 40;
    localparam int GROUP3_TESTS = 40;
    localparam int MUL_TESTS = 20;
    localparam int SHIFT_TESTS = 40;
    localparam int NUM_TESTS = 1 + GROUP1_TESTS + MEMREF_TESTS + GROUP3_TESTS +
                               MUL_TESTS + SHIFT_TESTS;

    logic clk;
    logic reset;
    logic start;
    ac_pkg::word_t instruction;
    ac_pkg::word_t operand;
    wire ac_pkg::word_t ac;
    wire ac_pkg::word_t mq;
    wire link;
    wire busy;
    wire done;

    int seed = 32'h259a8461;
    int error_count = 0;

    `include "ac_model.svh"

    ac_top dut
    (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .instruction (instruction),
        .operand     (operand),
        .ac          (ac),
        .mq          (mq),
        .link        (link),
        .busy        (busy),
        .done        (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(NUM_TESTS * 40 * CLK_PERIOD); // about 40 cycles per test
        $display("watchdog expired at %0t, the run did not finish", $time);
        $display("tests failed");
        $finish;
    end

    task automatic compare(input string name, input logic [11:0] got, input logic [11:0] want);
        if (got !== want)
        begin
            error_count++;
            $display("Error at time %0t: %s = %o, expected %o", $time, name, got, want);
        end
    endtask

    // one instruction with an optional second start while busy
    task automatic run_op(input ac_pkg::word_t instr, input ac_pkg::word_t opnd,
                          input logic busy_start);
        int latency;
        int cycles;
        logic seen;
        latency = predict(instr, opnd);
        @(posedge clk);
        instruction <= instr;
        operand <= opnd;
        start <= 1'b1;
        @(posedge clk); // start sampled here
        if (busy_start)
            instruction <= 12'o7240; // cla cma that must be ignored
        else
            start <= 1'b0;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < latency + 8)
        begin
            @(negedge clk);
            cycles++;
            if (done)
                seen = 1'b1;
            else if (busy_start && cycles == 1)
            begin
                if (!busy)
                begin
                    error_count++;
                    $display("busy was low at %0t while a second start was driven", $time);
                end
                @(posedge clk); // second start meets busy here
                start <= 1'b0;
            end
        end
        if (!seen)
        begin
            error_count++;
            $display("done never came for instruction %o within %0d cycles", instr, cycles);
        end
        else if (cycles != latency)
        begin
            error_count++;
            $display("done for instruction %o came %0d cycles after start instead of %0d",
                     instr, cycles, latency);
        end
        compare("busy", {11'b0, busy}, 12'o0);
        compare("ac", ac, exp_ac);
        compare("mq", mq, exp_mq);
        compare("link", {11'b0, link}, {11'b0, exp_link});
        @(negedge clk);
        compare("done", {11'b0, done}, 12'o0); // pulse lasts one cycle
    endtask

    // random ac, mq and link through ordinary instructions
    task automatic load_regs();
        logic [31:0] r;
        r = $random(seed);
        run_op(12'o7300, 12'o0000, 1'b0); // cla cll
        run_op(12'o1000, r[11:0], 1'b0); // tad then moved on to mq
        run_op(12'o7421, 12'o0000, 1'b0); // mql
        run_op(12'o1000, r[23:12], 1'b0);
        if (r[24])
            run_op(12'o7020, 12'o0000, 1'b0); // cml
    endtask

    initial
    begin
        logic [31:0] r;
        ac_pkg::word_t instr;
        ac_pkg::word_t opnd;
        reset = 1'b1;
        start = 1'b0;
        instruction = '0;
        operand = '0;
        exp_ac = '0;
        exp_mq = '0;
        exp_link = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare("ac", ac, 12'o0);
        compare("mq", mq, 12'o0);
        compare("link", {11'b0, link}, 12'o0);
        compare("busy", {11'b0, busy}, 12'o0);
        compare("done", {11'b0, done}, 12'o0);
        compare("eae_done", {11'b0, dut.u_eae.eae_done}, 12'o0);

        for (int i = 0; i < GROUP1_TESTS; i++)
        begin
            load_regs();
            r = $random(seed);
            instr = {3'o7, 1'b0, r[7:4], 3'(r[31:8] % 6), r[0]}; // valid rotate codes
            run_op(instr, r[19:8], 1'b0);
        end

        for (int i = 0; i < MEMREF_TESTS; i++)
        begin
            load_regs();
            r = $random(seed);
            instr = {r[31] ? 3'o1 : (r[30] ? 3'o3 : 3'o0), r[8:0]}; // half of them tad
            run_op(instr, r[20:9], 1'b0);
        end

        for (int i = 0; i < GROUP3_TESTS; i++)
        begin
            load_regs();
            r = $random(seed);
            instr = {3'o7, 1'b1, r[7:1], 1'b1};
            if (instr == 12'o7405 || instr == 12'o7413 || instr == 12'o7415 ||
                instr == 12'o7417)
                instr[3:1] = 3'b000; // keep it an mq micro-op
            run_op(instr, r[23:12], 1'b0);
        end

        for (int i = 0; i < MUL_TESTS; i++)
        begin
            load_regs();
            r = $random(seed);
            run_op(12'o7405, r[11:0], 1'b0);
        end

        for (int i = 0; i < SHIFT_TESTS; i++)
        begin
            load_regs();
            r = $random(seed);
            if (r[13:12] == 2'd0)
                instr = 12'o7413; // shl
            else if (r[13:12] == 2'd1)
                instr = 12'o7417; // lsr
            else
                instr = 12'o7415; // asr
            opnd = r[11:0];
            if (i < 2)
                opnd[4:0] = 5'(23 + i); // both sides of the limit
            run_op(instr, opnd, r[14]);
        end

        $display("run finished with %0d errors", error_count);
        if (error_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+design
+incdir+testbench
design/ac_pkg.sv
design/instr_decode.sv
design/operate_unit.sv
design/eae_unit.sv
design/ac_control.sv
design/ac_top.sv
testbench/ac_tb.sv

// File: run.sh
#!/bin/sh
# builds the accumulator unit testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module ac_tb -Mdir obj_dir -o ac_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ac_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

# the log decides pass or fail
if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0
